//--- vlog.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
dv/tb_ex_stage.sv

//--- run.sh
#!/usr/bin/env bash
# Build the EX stage testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ex_stage \
  --Mdir obj_dir -o tb_ex_stage > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_ex_stage 2>&1 | tee sim.log

grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"

//--- dv/tb_ex_stage.sv
// EX stage testbench
// Directed tests for ALU ops, branches, multiply with WB stalls,
// kill during a multiply, and reset/bubble behavior of the EX/WB register

module tb_ex_stage;

  import ex_pkg::*;

  // About 400 cycles of tests, five times that as the hang limit
  localparam int MAX_CYCLES  = 2000;
  // Four 8-bit steps plus the start cycle
  localparam int MUL_LATENCY = 32 / 8 + 1;

  logic   clk;
  logic   rst_n;
  id_ex_t id_ex;
  ctrl_t  ctrl;
  logic   wb_ready;
  logic   ex_ready;
  logic   ex_valid;
  ex_wb_t ex_wb;
  word_t  rf_wdata;
  logic   bch_dec;
  word_t  bch_target;

  int seed      = 32'h32d86ee8;
  int cycles    = 0;
  int errors    = 0;
  int checks    = 0;
  int tests_run = 0;

  ex_stage i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_i           (id_ex),
    .ctrl_i            (ctrl),
    .wb_ready_i        (wb_ready),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .ex_wb_o           (ex_wb),
    .rf_wdata_o        (rf_wdata),
    .branch_decision_o (bch_dec),
    .branch_target_o   (bch_target)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    $display("%s: %0d errors", name, errors - start);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Branch condition, also the set-less-than flag
  function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      // Negative values shift in ones
      ALU_SRA: return a[31] ? ~(~a >> b[4:0]) : a >> b[4:0];
      // Compares write back the zero-extended flag
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  function automatic word_t mul_model(mul_op_e op, word_t a, word_t b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    return (op == MUL_HU) ? prod[63:32] : prod[31:0];
  endfunction

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic id_ex_t alu_instr(alu_op_e op, word_t a, word_t b, reg_addr_t waddr);
    id_ex_t ins;
    ins             = '0;
    ins.instr_valid = 1'b1;
    ins.alu_en      = 1'b1;
    ins.alu_op      = op;
    ins.operand_a   = a;
    ins.operand_b   = b;
    ins.rf_we       = 1'b1;
    ins.rf_waddr    = waddr;
    ins.pc          = word_t'($random(seed)) & 32'hffff_fffc;
    return ins;
  endfunction

  function automatic id_ex_t mul_instr(mul_op_e op, word_t a, word_t b);
    id_ex_t ins;
    ins        = alu_instr(ALU_ADD, a, b, 5'd7);
    ins.alu_en = 1'b0;
    ins.mul_en = 1'b1;
    ins.mul_op = op;
    return ins;
  endfunction

  // Drive on the edge, return mid-cycle with outputs settled
  task automatic present(input id_ex_t ins);
    @(posedge clk);
    id_ex <= ins;
    @(negedge clk);
  endtask

  // Wait for the WB handshake, then drop the instruction on that edge
  task automatic retire();
    while (!(ex_valid && wb_ready)) @(negedge clk);
    @(posedge clk);
    id_ex.instr_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
  endtask

  // One multiply, WB stalled for hold cycles once the product shows up
  task automatic run_mul(input mul_op_e op, input word_t a, input word_t b, input int hold);
    word_t exp;
    word_t held;
    int    lat;
    exp = mul_model(op, a, b);
    lat = 0;
    @(posedge clk);
    id_ex    <= mul_instr(op, a, b);
    wb_ready <= (hold == 0);
    @(negedge clk);
    while (!ex_valid) begin
      check_flag("ex_ready_o", ex_ready, 1'b0);
      lat++;
      @(negedge clk);
    end
    checks++;
    if (lat != MUL_LATENCY) begin
      errors++;
      $display("** Error at %0t: ex_valid_o latency = %0d, expected %0d",
               $time, lat, MUL_LATENCY);
    end
    check_word("rf_wdata_o", rf_wdata, exp);
    held = ex_wb.rf_wdata;
    repeat (hold) begin
      @(negedge clk);
      check_flag("ex_valid_o", ex_valid, 1'b1);
      check_flag("ex_ready_o", ex_ready, 1'b0);
      check_word("rf_wdata_o", rf_wdata, exp);
      check_word("ex_wb_o.rf_wdata", ex_wb.rf_wdata, held);
    end
    if (hold > 0) begin
      @(posedge clk);
      wb_ready <= 1'b1;
      @(negedge clk);
    end
    retire();
    check_word("ex_wb_o.rf_wdata", ex_wb.rf_wdata, exp);
    check_addr("ex_wb_o.rf_waddr", ex_wb.rf_waddr, 5'd7);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_alu();
    id_ex_t ins;
    word_t  a;
    word_t  b;
    int     start;
    start = errors;
    for (int i = 0; i < 40; i++) begin
      a   = $random(seed);
      // Second pass over the ops uses equal operands so compares see both outcomes
      b   = (i >= 16 && i < 32) ? a : $random(seed);
      ins = alu_instr(alu_op_e'(i[3:0]), a, b, reg_addr_t'(i + 1));
      present(ins);
      retire();
      check_word("ex_wb_o.rf_wdata", ex_wb.rf_wdata, alu_model(ins.alu_op, a, b));
      check_addr("ex_wb_o.rf_waddr", ex_wb.rf_waddr, ins.rf_waddr);
      check_word("ex_wb_o.pc", ex_wb.pc, ins.pc);
      check_flag("ex_wb_o.bch_qual", ex_wb.bch_qual, 1'b0);
      check_flag("ex_wb_o.bch_taken_qual", ex_wb.bch_taken_qual, 1'b0);
    end
    finish_test("ALU operations", start);
  endtask

  task automatic test_branch();
    id_ex_t ins;
    word_t  a;
    word_t  b;
    logic   taken;
    int     start;
    start = errors;
    for (int i = 0; i < 24; i++) begin
      a             = $random(seed);
      b             = ((i / 6) % 2 == 1) ? a : $random(seed);
      ins           = alu_instr(alu_op_e'(4'(10 + i % 6)), a, b, '0);
      ins.bch       = 1'b1;
      ins.rf_we     = 1'b0;
      ins.operand_c = $random(seed);
      taken         = cmp_model(ins.alu_op, a, b);
      present(ins);
      check_flag("branch_decision_o", bch_dec, taken);
      check_word("branch_target_o", bch_target, ins.operand_c);
      retire();
      check_flag("ex_wb_o.bch_qual", ex_wb.bch_qual, 1'b1);
      check_flag("ex_wb_o.bch_taken_qual", ex_wb.bch_taken_qual, taken);
    end
    finish_test("Branches", start);
  endtask

  task automatic test_mul();
    int start;
    start = errors;
    run_mul(MUL_LO, $random(seed), $random(seed), 3);
    run_mul(MUL_HU, $random(seed), $random(seed), 3);
    run_mul(MUL_HU, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_mul(MUL_LO, $random(seed), $random(seed), 0);
    finish_test("Multiply with back-pressure", start);
  endtask

  task automatic test_kill();
    int start;
    start = errors;
    @(posedge clk);
    id_ex <= mul_instr(MUL_LO, $random(seed), $random(seed));
    repeat (2) @(posedge clk);
    ctrl.kill_ex <= 1'b1;
    // Killed multiply stays in place past the point where it would have finished
    repeat (MUL_LATENCY) begin
      @(negedge clk);
      check_flag("ex_ready_o", ex_ready, 1'b1);
      check_flag("ex_valid_o", ex_valid, 1'b0);
      check_flag("ex_wb_o.instr_valid", ex_wb.instr_valid, 1'b0);
    end
    @(posedge clk);
    id_ex.instr_valid <= 1'b0;
    ctrl.kill_ex      <= 1'b0;
    @(negedge clk);
    check_flag("ex_wb_o.instr_valid", ex_wb.instr_valid, 1'b0);
    // Next multiply has to start from IDLE with full latency
    run_mul(MUL_LO, 32'h1234_5678, 32'h9abc_def0, 0);
    finish_test("Kill during multiply", start);
  endtask

  task automatic test_reset();
    id_ex_t ins;
    int     start;
    start = errors;
    // Accepted result in EX/WB and a finished multiply held by WB when reset hits
    present(alu_instr(ALU_OR, $random(seed), $random(seed), 5'd9));
    @(posedge clk);
    id_ex    <= mul_instr(MUL_LO, $random(seed), $random(seed));
    wb_ready <= 1'b0;
    @(negedge clk);
    while (!ex_valid) @(negedge clk);
    apply_reset();
    check_flag("ex_wb_o.instr_valid", ex_wb.instr_valid, 1'b0);
    check_flag("ex_wb_o.rf_we", ex_wb.rf_we, 1'b0);
    check_flag("ex_valid_o", ex_valid, 1'b0);
    @(posedge clk);
    id_ex.instr_valid <= 1'b0;
    wb_ready          <= 1'b1;
    @(negedge clk);
    // Known write first, then one with rf_we clear on top
    present(alu_instr(ALU_ADD, 32'h0000_1000, 32'h0000_0234, 5'd3));
    retire();
    ins       = alu_instr(ALU_XOR, $random(seed), $random(seed), 5'd12);
    ins.rf_we = 1'b0;
    present(ins);
    retire();
    check_flag("ex_wb_o.instr_valid", ex_wb.instr_valid, 1'b1);
    check_flag("ex_wb_o.rf_we", ex_wb.rf_we, 1'b0);
    check_word("ex_wb_o.rf_wdata", ex_wb.rf_wdata, 32'h0000_1234);
    check_addr("ex_wb_o.rf_waddr", ex_wb.rf_waddr, 5'd3);
    // Empty EX with WB ready sends a bubble
    @(negedge clk);
    check_flag("ex_wb_o.instr_valid", ex_wb.instr_valid, 1'b0);
    finish_test("Reset and bubbles", start);
  endtask

  initial begin
    rst_n    <= 1'b0;
    id_ex    <= '0;
    ctrl     <= '0;
    wb_ready <= 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_alu();
    test_branch();
    test_mul();
    test_kill();
    test_reset();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- hdl/ex_stage.sv
// Execute stage top
// Gates the decoded instruction with kill/halt, runs it through the ALU
// or the iterative multiplier, and hands the result to WB over ready/valid

module ex_stage #(
  parameter int unsigned MUL_STEP_W = 8
) (
  input  logic           clk,
  input  logic           rst_n,
  input  ex_pkg::id_ex_t id_ex_i,
  input  ex_pkg::ctrl_t  ctrl_i,
  input  logic           wb_ready_i,
  output logic           ex_ready_o,
  output logic           ex_valid_o,
  output ex_pkg::ex_wb_t ex_wb_o,
  output ex_pkg::word_t  rf_wdata_o,
  output logic           branch_decision_o,
  output ex_pkg::word_t  branch_target_o
);

  import ex_pkg::*;

  logic  instr_valid;
  logic  mul_en_gated;
  logic  mul_ready;
  logic  mul_valid;
  word_t alu_result;
  logic  alu_cmp_result;
  word_t mul_result;

  // Kill or halt drops the instruction and resets the multiplier
  assign instr_valid  = id_ex_i.instr_valid && !ctrl_i.kill_ex && !ctrl_i.halt_ex;
  assign mul_en_gated = id_ex_i.mul_en && instr_valid;

  // Write data, also forwarded to ID
  assign rf_wdata_o = id_ex_i.mul_en ? mul_result : alu_result;

  // To fetch
  assign branch_decision_o = alu_cmp_result;
  assign branch_target_o   = id_ex_i.operand_c;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu i_alu (
    .operator_i   (id_ex_i.alu_op),
    .operand_a_i  (id_ex_i.operand_a),
    .operand_b_i  (id_ex_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult #(
    .MUL_STEP_W (MUL_STEP_W)
  ) i_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (id_ex_i.mul_op),
    .op_a_i     (id_ex_i.operand_a),
    .op_b_i     (id_ex_i.operand_b),
    .valid_i    (mul_en_gated),
    .ready_i    (wb_ready_i),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .result_o   (mul_result)
  );

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  // Kill always frees the stage; otherwise WB and a pending multiply decide
  assign ex_ready_o = ctrl_i.kill_ex ||
                      (!ctrl_i.halt_ex && wb_ready_i && (!mul_en_gated || mul_ready));

  // ALU results are valid at once, multiplies wait for DONE
  assign ex_valid_o = instr_valid && (!id_ex_i.mul_en || mul_valid);

  ex_wb_reg i_ex_wb_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .accept_i    (ex_valid_o && wb_ready_i),
    .bubble_i    (!ex_valid_o && wb_ready_i),
    .id_ex_i     (id_ex_i),
    .wdata_i     (rf_wdata_o),
    .bch_taken_i (branch_decision_o),
    .ex_wb_o     (ex_wb_o)
  );

  // Decoder selects exactly one unit per instruction
  assert property (@(posedge clk) disable iff (!rst_n)
    id_ex_i.instr_valid |-> !(id_ex_i.alu_en && id_ex_i.mul_en));

endmodule

//--- hdl/ex_wb_reg.sv
// EX/WB pipeline register
// Captures the accepted instruction and its qualified branch flags,
// and clears the valid bit when a bubble goes down the pipe

module ex_wb_reg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           accept_i,
  input  logic           bubble_i,
  input  ex_pkg::id_ex_t id_ex_i,
  input  ex_pkg::word_t  wdata_i,
  input  logic           bch_taken_i,
  output ex_pkg::ex_wb_t ex_wb_o
);

  //////////////////////////////////////////////////
  // Register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_o <= '0;
    end else begin
      if (accept_i) begin
        ex_wb_o.instr_valid <= 1'b1;
        ex_wb_o.rf_we       <= id_ex_i.rf_we;
        ex_wb_o.pc          <= id_ex_i.pc;

        // Address and data only move for instructions that write back
        if (id_ex_i.rf_we) begin
          ex_wb_o.rf_waddr <= id_ex_i.rf_waddr;
          ex_wb_o.rf_wdata <= wdata_i;
        end

        // Branch flags qualified by the ALU enable
        ex_wb_o.bch_qual       <= id_ex_i.bch && id_ex_i.alu_en;
        ex_wb_o.bch_taken_qual <= id_ex_i.bch && id_ex_i.alu_en && bch_taken_i;
      end else if (bubble_i) begin
        // WB is ready but nothing valid in EX
        ex_wb_o.instr_valid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Stage handshake never asks for both at once
  assert property (@(posedge clk) disable iff (!rst_n)
    !(accept_i && bubble_i));

endmodule

//--- hdl/ex_mult.sv
// Iterative unsigned multiplier
// Shift-add over MUL_STEP_W bits of operand b per cycle, with a
// valid/ready handshake; returns the low or high word of the product

module ex_mult #(
  parameter int unsigned MUL_STEP_W = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  logic            valid_i,
  input  logic            ready_i,
  output logic            ready_o,
  output logic            valid_o,
  output ex_pkg::word_t   result_o
);

  import ex_pkg::*;

  localparam int unsigned STEPS = 32 / MUL_STEP_W;
  localparam int unsigned CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

  mul_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [63:0]      acc_q;
  logic [63:0]      mcand_q;
  word_t            mplier_q;
  logic [63:0]      partial;

  // Multiplicand times the current slice of operand b
  assign partial = mcand_q * 64'(mplier_q[MUL_STEP_W-1:0]);

  //////////////////////////////////////////////////
  // FSM and datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      acc_q    <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          // Start as soon as a gated multiply shows up
          if (valid_i) begin
            state_q  <= BUSY;
            cnt_q    <= '0;
            acc_q    <= '0;
            mcand_q  <= {32'b0, op_a_i};
            mplier_q <= op_b_i;
          end
        end
        BUSY: begin
          if (!valid_i) begin
            // Killed or halted mid-way
            state_q <= IDLE;
          end else begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_STEP_W;
            mplier_q <= mplier_q >> MUL_STEP_W;
            cnt_q    <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(STEPS - 1)) begin
              state_q <= DONE;
            end
          end
        end
        DONE: begin
          // Hold the product until WB takes it
          if (!valid_i || ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign valid_o  = (state_q == DONE);
  assign ready_o  = (state_q == DONE) && ready_i;
  assign result_o = (operator_i == MUL_HU) ? acc_q[63:32] : acc_q[31:0];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Product shows up STEPS + 1 cycles after the start was taken in IDLE
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(valid_o) |-> $past(state_q == IDLE && valid_i, STEPS + 1));

  if (32 % MUL_STEP_W != 0) begin : g_step_check
    $error("MUL_STEP_W must divide 32");
  end

endmodule

//--- hdl/ex_alu.sv
// Single-cycle ALU
// Add/sub, logic, shifts, set-less-than and the branch compares, with a
// separate compare flag for the branch decision

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  import ex_pkg::*;

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////

  logic        sub_en;
  word_t       b_inv;
  logic [32:0] sum;
  logic        is_equal;
  logic        lt_signed;
  logic        lt_unsigned;
  logic [4:0]  shamt;

  // Everything except a plain add runs the adder as a subtractor
  assign sub_en = (operator_i != ALU_ADD);
  assign b_inv  = sub_en ? ~operand_b_i : operand_b_i;

  // Carry-in of one completes the two's complement
  assign sum = {1'b0, operand_a_i} + {1'b0, b_inv} + {32'b0, sub_en};

  // Carry out set means a >= b unsigned
  assign lt_unsigned = ~sum[32];

  // Signs differ: the negative one is smaller
  assign lt_signed = (operand_a_i[31] ^ operand_b_i[31]) ? operand_a_i[31] : sum[31];

  assign is_equal = (operand_a_i == operand_b_i);

  // Only the low five bits count for 32-bit shifts
  assign shamt = operand_b_i[4:0];

  //////////////////////////////////////////////////
  // Compare flag
  //////////////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      ALU_EQ:           cmp_result_o = is_equal;
      ALU_NE:           cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:  cmp_result_o = lt_signed;
      ALU_GE:           cmp_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:          cmp_result_o = ~lt_unsigned;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      ALU_ADD, ALU_SUB: result_o = sum[31:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = operand_a_i << shamt;
      ALU_SRL:          result_o = operand_a_i >> shamt;
      ALU_SRA:          result_o = word_t'($signed(operand_a_i) >>> shamt);
      // Set-less-than and compares give the zero-extended flag
      default:          result_o = {31'b0, cmp_result_o};
    endcase
  end

endmodule

//--- hdl/ex_pkg.sv
// Execute stage shared types
// Data word and register address widths, ALU and multiplier operation
// encodings, and the ID/EX, EX/WB and controller structs

package ex_pkg;

  //////////////////////////////////////////////////
  // Basic widths
  //////////////////////////////////////////////////

  // Operands, results, pc and branch target
  typedef logic [31:0] word_t;

  // Register file address
  typedef logic [4:0]  reg_addr_t;

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////

  // ALU operations, branch compares at the top of the range
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Low or high word of the unsigned product
  typedef enum logic {
    MUL_LO,
    MUL_HU
  } mul_op_e;

  // Iterative multiplier FSM
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mul_state_e;

  //////////////////////////////////////////////////
  // Pipeline structs
  //////////////////////////////////////////////////

  // Decoded instruction from ID
  typedef struct packed {
    logic      instr_valid;
    logic      alu_en;
    alu_op_e   alu_op;
    logic      mul_en;
    mul_op_e   mul_op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     operand_c;   // Branch target
    logic      bch;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     pc;
  } id_ex_t;

  // Result toward WB
  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    word_t     pc;
    logic      bch_qual;
    logic      bch_taken_qual;
  } ex_wb_t;

  // Controller requests for EX
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_t;

endpackage
